//--- hw/replay_pkg.sv
//**************************************************************************
// Shared widths, depths and read latency of the replay read engine,
// plus the replay memory address view (queue id + offset, or flat index)
//**************************************************************************

package replay_pkg;

  // Queues and memory regions
  localparam int NUM_QUEUES = 4;
  localparam int QID_W      = 2;
  localparam int OFFSET_W   = 6;
  localparam int ADDR_W     = QID_W + OFFSET_W;

  // Replay word
  localparam int DATA_W = 32;

  // Cycles from read request to read data valid
  localparam int MEM_LAT = 2;

  // FIFO sizing
  localparam int TAG_DEPTH_BITS  = 3;
  localparam int QBUF_DEPTH_BITS = 4;

  // Free entries left when nearly full asserts, enough for every read in flight
  localparam int QBUF_RESERVE = 4;

  // Replay memory address
  // Region select in the upper bits, word offset inside the region below
  typedef union packed {
    struct packed {
      logic [QID_W-1:0]    qid;
      logic [OFFSET_W-1:0] offset;
    } fields;
    logic [ADDR_W-1:0] flat;
  } replay_addr_u;

endpackage

//--- hw/replay_mem.sv
//**************************************************************************
// Replay memory: host write port and a fixed-latency pipelined read port
//**************************************************************************

`timescale 1ns/1ns

module replay_mem (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            wr_en,
  input  replay_pkg::replay_addr_u        wr_addr,
  input  logic [replay_pkg::DATA_W-1:0]   wr_data,
  input  logic                            rd_en,
  input  replay_pkg::replay_addr_u        rd_addr,
  output logic                            rd_valid,
  output logic [replay_pkg::DATA_W-1:0]   rd_data
);

  logic [replay_pkg::DATA_W-1:0] mem [2**replay_pkg::ADDR_W];

  // One valid bit per pipeline stage
  logic [replay_pkg::MEM_LAT-1:0] vld_pipe;

  // Addresses follow the valid bits until the array is read in the last stage
  logic [replay_pkg::ADDR_W-1:0] addr_pipe [replay_pkg::MEM_LAT-1];
  logic [replay_pkg::DATA_W-1:0] data_q;

  // Host load
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr.flat] <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      vld_pipe <= '0;
    end else begin
      vld_pipe <= {vld_pipe[replay_pkg::MEM_LAT-2:0], rd_en};
    end
  end

  always_ff @(posedge clk) begin
    addr_pipe[0] <= rd_addr.flat;
    for (int i = 1; i < replay_pkg::MEM_LAT - 1; i++) begin
      addr_pipe[i] <= addr_pipe[i-1];
    end
    data_q <= mem[addr_pipe[replay_pkg::MEM_LAT-2]];
  end

  assign rd_valid = vld_pipe[replay_pkg::MEM_LAT-1];
  assign rd_data  = data_q;

endmodule

//--- hw/tag_fifo.sv
//**************************************************************************
// Small first-word-fall-through FIFO with empty, full and nearly-full
// Serves as the read tag FIFO and as each queue buffer
//**************************************************************************

`timescale 1ns/1ns

module tag_fifo #(
  parameter int WIDTH      = 8,
  parameter int DEPTH_BITS = 3
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             wr_en,
  input  logic [WIDTH-1:0] din,
  input  logic             rd_en,
  output logic [WIDTH-1:0] dout,
  output logic             empty,
  output logic             full,
  output logic             nearly_full
);

  localparam int DEPTH = 1 << DEPTH_BITS;

  logic [WIDTH-1:0]      mem [DEPTH];
  logic [DEPTH_BITS-1:0] wr_ptr;
  logic [DEPTH_BITS-1:0] rd_ptr;
  logic [DEPTH_BITS:0]   count;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves the count alone
      if (wr_en && !rd_en) begin
        count <= count + 1'b1;
      end else if (rd_en && !wr_en) begin
        count <= count - 1'b1;
      end
    end
  end

  // Oldest entry is always on the output
  assign dout  = mem[rd_ptr];
  assign empty = (count == '0);
  assign full  = (int'(count) == DEPTH);

  // Free entries at or below the reserve
  assign nearly_full = (int'(count) >= DEPTH - replay_pkg::QBUF_RESERVE);

  // Callers throttle on the flags, so overflow or underflow is a system bug
  a_no_overflow: assert property (@(posedge clk) disable iff (rst)
    !(wr_en && full));

  a_no_underflow: assert property (@(posedge clk) disable iff (rst)
    !(rd_en && empty));

endmodule

//--- hw/mem_read_sched.sv
//**************************************************************************
// Round-robin replay read scheduler
// Per-queue head pointers, read issue, tag FIFO and return-data steering
//**************************************************************************

`timescale 1ns/1ns

module mem_read_sched (
  input  logic                                                    clk,
  input  logic                                                    rst,
  input  logic                                                    start,
  input  logic [replay_pkg::NUM_QUEUES-1:0][replay_pkg::OFFSET_W-1:0] tail,
  output logic [replay_pkg::NUM_QUEUES-1:0][replay_pkg::OFFSET_W-1:0] head,
  output logic                                                    rd_en,
  output replay_pkg::replay_addr_u                                rd_addr,
  input  logic                                                    rd_valid,
  input  logic [replay_pkg::DATA_W-1:0]                           rd_data,
  input  logic [replay_pkg::NUM_QUEUES-1:0]                       qbuf_nearly_full,
  output logic [replay_pkg::NUM_QUEUES-1:0]                       qbuf_wr_en,
  output logic [replay_pkg::DATA_W-1:0]                           qbuf_wr_data
);

  // Two-phase cycle of choose then issue
  logic in_issue;

  logic [replay_pkg::QID_W-1:0] last_qid;
  logic [replay_pkg::QID_W-1:0] sel_qid;
  logic                         sel_vld;

  logic [replay_pkg::NUM_QUEUES-1:0] eligible;
  logic [replay_pkg::QID_W-1:0]      cand;
  logic [replay_pkg::QID_W-1:0]      pick;
  logic                              found;

  logic [replay_pkg::QID_W-1:0] tag_dout;
  logic                         tag_empty;
  logic                         tag_full;

  // Queue has words left and room in its buffer
  always_comb begin
    for (int q = 0; q < replay_pkg::NUM_QUEUES; q++) begin
      eligible[q] = start && (head[q] != tail[q]) && !qbuf_nearly_full[q];
    end
  end

  // Search starts just after the last queue served and wraps to it last
  always_comb begin
    found = 1'b0;
    pick  = last_qid;
    cand  = last_qid;
    for (int i = 1; i <= replay_pkg::NUM_QUEUES; i++) begin
      cand = last_qid + i[replay_pkg::QID_W-1:0];
      if (!found && eligible[cand]) begin
        found = 1'b1;
        pick  = cand;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      in_issue <= 1'b0;
      sel_vld  <= 1'b0;
      sel_qid  <= '0;
      last_qid <= '1;
      head     <= '0;
    end else if (!in_issue) begin
      in_issue <= 1'b1;
      sel_vld  <= found;
      sel_qid  <= pick;
    end else begin
      in_issue <= 1'b0;
      if (sel_vld) begin
        head[sel_qid] <= head[sel_qid] + 1'b1;
        last_qid      <= sel_qid;
      end
    end
  end

  // Read address with the region picked by queue id
  assign rd_en = in_issue && sel_vld;

  always_comb begin
    rd_addr.fields.qid    = sel_qid;
    rd_addr.fields.offset = head[sel_qid];
  end

  // Queue ids of reads in flight in issue order
  tag_fifo #(
    .WIDTH      (replay_pkg::QID_W),
    .DEPTH_BITS (replay_pkg::TAG_DEPTH_BITS)
  ) u_tag_fifo (
    .clk         (clk),
    .rst         (rst),
    .wr_en       (rd_en),
    .din         (sel_qid),
    .rd_en       (rd_valid),
    .dout        (tag_dout),
    .empty       (tag_empty),
    .full        (tag_full),
    .nearly_full ()
  );

  // Returning word goes to the buffer named by the oldest tag
  // No back-pressure here because nearly_full already reserved the space
  always_comb begin
    qbuf_wr_en = '0;
    if (rd_valid) begin
      qbuf_wr_en[tag_dout] = 1'b1;
    end
  end

  assign qbuf_wr_data = rd_data;

  // Every returning word must have a tag from an earlier issue
  a_tag_present: assert property (@(posedge clk) disable iff (rst)
    rd_valid |-> !tag_empty);

  // One issue per two cycles keeps the reads in flight well below the tag depth
  a_tag_room: assert property (@(posedge clk) disable iff (rst)
    rd_en |-> !tag_full);

endmodule

//--- hw/replay_egress.sv
//**************************************************************************
// Egress merge: round-robin pop of the queue buffers into one
// registered valid/ready output stream tagged with the queue id
//**************************************************************************

`timescale 1ns/1ns

module replay_egress (
  input  logic                                                  clk,
  input  logic                                                  rst,
  input  logic [replay_pkg::NUM_QUEUES-1:0]                     qbuf_empty,
  input  logic [replay_pkg::NUM_QUEUES-1:0][replay_pkg::DATA_W-1:0] qbuf_dout,
  output logic [replay_pkg::NUM_QUEUES-1:0]                     qbuf_rd_en,
  output logic                                                  out_valid,
  output logic [replay_pkg::DATA_W-1:0]                         out_data,
  output logic [replay_pkg::QID_W-1:0]                          out_qid,
  input  logic                                                  out_ready
);

  logic [replay_pkg::QID_W-1:0] last_grant;
  logic [replay_pkg::QID_W-1:0] cand;
  logic [replay_pkg::QID_W-1:0] grant_qid;
  logic                         grant_vld;
  logic                         load_ok;

  // Register free now, or emptied by a transfer on this edge
  assign load_ok = !out_valid || out_ready;

  always_comb begin
    grant_vld = 1'b0;
    grant_qid = last_grant;
    cand      = last_grant;
    for (int i = 1; i <= replay_pkg::NUM_QUEUES; i++) begin
      cand = last_grant + i[replay_pkg::QID_W-1:0];
      if (!grant_vld && !qbuf_empty[cand]) begin
        grant_vld = 1'b1;
        grant_qid = cand;
      end
    end
  end

  always_comb begin
    qbuf_rd_en = '0;
    if (load_ok && grant_vld) begin
      qbuf_rd_en[grant_qid] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid  <= 1'b0;
      last_grant <= '1;
    end else if (load_ok) begin
      out_valid <= grant_vld;
      if (grant_vld) begin
        last_grant <= grant_qid;
      end
    end
  end

  // Word and tag captured from the fall-through output of the popped buffer
  always_ff @(posedge clk) begin
    if (load_ok && grant_vld) begin
      out_data <= qbuf_dout[grant_qid];
      out_qid  <= grant_qid;
    end
  end

  a_stall_stable: assert property (@(posedge clk) disable iff (rst)
    (out_valid && !out_ready) |=>
      (out_valid && $stable(out_data) && $stable(out_qid)));

endmodule

//--- hw/pcap_replay_top.sv
//**************************************************************************
// Replay read engine top: memory, read scheduler, four queue buffers
// and the egress merge
//**************************************************************************

`timescale 1ns/1ns

module pcap_replay_top (
  input  logic                                                    clk,
  input  logic                                                    rst,
  input  logic                                                    start,
  input  logic                                                    wr_en,
  input  replay_pkg::replay_addr_u                                wr_addr,
  input  logic [replay_pkg::DATA_W-1:0]                           wr_data,
  input  logic [replay_pkg::NUM_QUEUES-1:0][replay_pkg::OFFSET_W-1:0] tail,
  output logic [replay_pkg::NUM_QUEUES-1:0][replay_pkg::OFFSET_W-1:0] head,
  output logic                                                    out_valid,
  output logic [replay_pkg::DATA_W-1:0]                           out_data,
  output logic [replay_pkg::QID_W-1:0]                            out_qid,
  input  logic                                                    out_ready
);

  // Everything idles in reset until the host raises start
  logic run_rst;

  logic                          rd_en;
  replay_pkg::replay_addr_u      rd_addr;
  logic                          rd_valid;
  logic [replay_pkg::DATA_W-1:0] rd_data;

  logic [replay_pkg::NUM_QUEUES-1:0]                         qbuf_wr_en;
  logic [replay_pkg::DATA_W-1:0]                             qbuf_wr_data;
  logic [replay_pkg::NUM_QUEUES-1:0]                         qbuf_nearly_full;
  logic [replay_pkg::NUM_QUEUES-1:0]                         qbuf_empty;
  logic [replay_pkg::NUM_QUEUES-1:0]                         qbuf_rd_en;
  logic [replay_pkg::NUM_QUEUES-1:0][replay_pkg::DATA_W-1:0] qbuf_dout;

  assign run_rst = rst || !start;

  replay_mem u_replay_mem (
    .clk      (clk),
    .rst      (run_rst),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .rd_en    (rd_en),
    .rd_addr  (rd_addr),
    .rd_valid (rd_valid),
    .rd_data  (rd_data)
  );

  mem_read_sched u_mem_read_sched (
    .clk              (clk),
    .rst              (run_rst),
    .start            (start),
    .tail             (tail),
    .head             (head),
    .rd_en            (rd_en),
    .rd_addr          (rd_addr),
    .rd_valid         (rd_valid),
    .rd_data          (rd_data),
    .qbuf_nearly_full (qbuf_nearly_full),
    .qbuf_wr_en       (qbuf_wr_en),
    .qbuf_wr_data     (qbuf_wr_data)
  );

  // One buffer per output queue
  for (genvar q = 0; q < replay_pkg::NUM_QUEUES; q++) begin : g_qbuf
    tag_fifo #(
      .WIDTH      (replay_pkg::DATA_W),
      .DEPTH_BITS (replay_pkg::QBUF_DEPTH_BITS)
    ) u_qbuf (
      .clk         (clk),
      .rst         (run_rst),
      .wr_en       (qbuf_wr_en[q]),
      .din         (qbuf_wr_data),
      .rd_en       (qbuf_rd_en[q]),
      .dout        (qbuf_dout[q]),
      .empty       (qbuf_empty[q]),
      .full        (),
      .nearly_full (qbuf_nearly_full[q])
    );
  end

  replay_egress u_replay_egress (
    .clk        (clk),
    .rst        (run_rst),
    .qbuf_empty (qbuf_empty),
    .qbuf_dout  (qbuf_dout),
    .qbuf_rd_en (qbuf_rd_en),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .out_qid    (out_qid),
    .out_ready  (out_ready)
  );

endmodule

//--- verification/tb_pcap_replay.sv
//**************************************************************************
// Testbench for the replay read engine: test table, memory loader,
// per-queue reference model and typed compare tasks
//**************************************************************************

`timescale 1ns/1ns

module tb_pcap_replay;

  localparam int NUM_ROWS        = 7;
  localparam int COLLECT_TIMEOUT = 20000;
  localparam int QUIET_CYCLES    = 50;

  logic                                                          clk;
  logic                                                          rst;
  logic                                                          start;
  logic                                                          wr_en;
  replay_pkg::replay_addr_u                                      wr_addr;
  logic [replay_pkg::DATA_W-1:0]                                 wr_data;
  logic [replay_pkg::NUM_QUEUES-1:0][replay_pkg::OFFSET_W-1:0]   tail;
  logic [replay_pkg::NUM_QUEUES-1:0][replay_pkg::OFFSET_W-1:0]   head;
  logic                                                          out_valid;
  logic [replay_pkg::DATA_W-1:0]                                 out_data;
  logic [replay_pkg::QID_W-1:0]                                  out_qid;
  logic                                                          out_ready;

  // Test table
  string                                                       row_name  [NUM_ROWS];
  logic [replay_pkg::NUM_QUEUES-1:0][replay_pkg::OFFSET_W-1:0] row_tail  [NUM_ROWS];
  int                                                          row_stall [NUM_ROWS];
  int                                                          row_hold  [NUM_ROWS];
  int                                                          row_total [NUM_ROWS];

  // Reference copy of the replay memory and delivery counters
  logic [replay_pkg::DATA_W-1:0] ref_mem [2**replay_pkg::ADDR_W];
  int                            got [replay_pkg::NUM_QUEUES];
  int                            rx_count;
  logic [31:0]                   rng_state;
  int                            mismatch_count;
  int                            other_count;

  // Output state seen at the previous falling edge
  logic                          was_stalled;
  logic [replay_pkg::DATA_W-1:0] held_data;
  logic [replay_pkg::QID_W-1:0]  held_qid;

  pcap_replay_top u_dut (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .tail      (tail),
    .head      (head),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_qid   (out_qid),
    .out_ready (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_word(input string label, input logic [replay_pkg::DATA_W-1:0] expected,
                            input logic [replay_pkg::DATA_W-1:0] actual);
    if (actual !== expected) begin
      mismatch_count++;
      $display("Mismatch %s: expected %08h actual %08h", label, expected, actual);
    end
  endtask

  task automatic check_qid(input string label, input logic [replay_pkg::QID_W-1:0] expected,
                           input logic [replay_pkg::QID_W-1:0] actual);
    if (actual !== expected) begin
      mismatch_count++;
      $display("Mismatch %s: expected %0d actual %0d", label, expected, actual);
    end
  endtask

  task automatic check_offset(input string label,
                              input logic [replay_pkg::OFFSET_W-1:0] expected,
                              input logic [replay_pkg::OFFSET_W-1:0] actual);
    if (actual !== expected) begin
      mismatch_count++;
      $display("Mismatch %s: expected %0d actual %0d", label, expected, actual);
    end
  endtask

  task automatic set_row(input int r, input string name, input int t0, input int t1,
                         input int t2, input int t3, input int stall, input int hold,
                         input int total);
    row_name[r]    = name;
    row_tail[r][0] = t0[replay_pkg::OFFSET_W-1:0];
    row_tail[r][1] = t1[replay_pkg::OFFSET_W-1:0];
    row_tail[r][2] = t2[replay_pkg::OFFSET_W-1:0];
    row_tail[r][3] = t3[replay_pkg::OFFSET_W-1:0];
    row_stall[r]   = stall;
    row_hold[r]    = hold;
    row_total[r]   = total;
  endtask

  // Model: the k-th word of queue q is memory word (q, k)
  task automatic accept_word(input string name);
    replay_pkg::replay_addr_u ea;
    int                       q;
    q = int'(out_qid);
    if (got[q] >= int'(tail[q])) begin
      other_count++;
      $display("Unexpected extra word from queue %0d in test %s", q, name);
    end else begin
      ea.fields.qid    = out_qid;
      ea.fields.offset = got[q][replay_pkg::OFFSET_W-1:0];
      check_word($sformatf("%s q%0d word %0d", name, q, got[q]), ref_mem[ea.flat], out_data);
    end
    got[q]++;
    rx_count++;
  endtask

  // One cycle on the output side; a transfer happens on the next rising edge
  task automatic step_output(input string name, input int pct, input bit hold);
    @(negedge clk);
    rng_state = next_random(rng_state);
    if (hold) begin
      out_ready = 1'b0;
    end else begin
      out_ready = ((rng_state % 32'd100) >= 32'(pct));
    end
    if (was_stalled) begin
      if (!out_valid) begin
        other_count++;
        $display("out_valid dropped while stalled in test %s", name);
      end
      check_word({name, " held data"}, held_data, out_data);
      check_qid({name, " held qid"}, held_qid, out_qid);
    end
    if (out_valid && out_ready) begin
      accept_word(name);
    end
    was_stalled = out_valid && !out_ready;
    held_data   = out_data;
    held_qid    = out_qid;
  endtask

  task automatic run_row(input int r);
    string name;
    int    cyc;
    name = row_name[r];
    @(negedge clk);
    start     = 1'b0;
    out_ready = 1'b1;
    // Fresh random contents in every region
    for (int a = 0; a < 2**replay_pkg::ADDR_W; a++) begin
      @(negedge clk);
      rng_state    = next_random(rng_state);
      wr_en        = 1'b1;
      wr_addr.flat = a[replay_pkg::ADDR_W-1:0];
      wr_data      = rng_state;
      ref_mem[a]   = rng_state;
      if (out_valid) begin
        other_count++;
        $display("out_valid high while start is low in test %s", name);
      end
    end
    @(negedge clk);
    wr_en = 1'b0;
    for (int q = 0; q < replay_pkg::NUM_QUEUES; q++) begin
      check_offset($sformatf("%s idle head %0d", name, q), '0, head[q]);
    end
    tail        = row_tail[r];
    start       = 1'b1;
    rx_count    = 0;
    was_stalled = 1'b0;
    for (int q = 0; q < replay_pkg::NUM_QUEUES; q++) begin
      got[q] = 0;
    end
    cyc = 0;
    while (rx_count < row_total[r] && cyc < COLLECT_TIMEOUT) begin
      step_output(name, row_stall[r], cyc < row_hold[r]);
      cyc++;
    end
    if (rx_count < row_total[r]) begin
      other_count++;
      $display("Timeout in test %s: %0d of %0d words received", name, rx_count, row_total[r]);
    end
    // Nothing more may come out once the expected total is in
    repeat (QUIET_CYCLES) step_output(name, 0, 1'b0);
    if (rx_count > row_total[r]) begin
      other_count++;
      $display("Test %s delivered %0d words beyond the expected total", name,
               rx_count - row_total[r]);
    end
    for (int q = 0; q < replay_pkg::NUM_QUEUES; q++) begin
      check_offset($sformatf("%s count q%0d", name, q), tail[q],
                   got[q][replay_pkg::OFFSET_W-1:0]);
      check_offset($sformatf("%s final head %0d", name, q), tail[q], head[q]);
    end
  endtask

  initial begin
    rst            = 1'b1;
    start          = 1'b0;
    wr_en          = 1'b0;
    wr_addr        = '0;
    wr_data        = '0;
    tail           = '0;
    out_ready      = 1'b0;
    rng_state      = 32'd55449;
    mismatch_count = 0;
    other_count    = 0;
    was_stalled    = 1'b0;
    held_data      = '0;
    held_qid       = '0;

    //      row  name            tails            stall  hold  total
    set_row(0, "no_stall",       5,  9,  3, 12,   0,     0,    29);
    set_row(1, "empty_queues",   0, 17,  0,  6,   0,     0,    23);
    set_row(2, "full_regions",  63,  1, 63,  2,   0,     0,   129);
    set_row(3, "stall_50",      20, 33,  7, 15,  50,     0,    75);
    set_row(4, "stall_80",      31,  0, 25, 44,  80,     0,   100);
    set_row(5, "reserve_hold",  40, 40, 40, 40,   0,   200,   160);
    set_row(6, "single_queue",   0,  0, 50,  0,  50,     0,    50);

    repeat (10) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    if (out_valid) begin
      other_count++;
      $display("out_valid high after reset");
    end
    for (int q = 0; q < replay_pkg::NUM_QUEUES; q++) begin
      check_offset($sformatf("reset head %0d", q), '0, head[q]);
    end

    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(r);
    end

    $display("Error counts: %0d mismatches, %0d other failures", mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- files.f
hw/replay_pkg.sv
hw/replay_mem.sv
hw/tag_fifo.sv
hw/mem_read_sched.sv
hw/replay_egress.sv
hw/pcap_replay_top.sv
verification/tb_pcap_replay.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the replay read engine testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  --top-module tb_pcap_replay \
  -f files.f

./obj_dir/Vtb_pcap_replay | tee sim.log

if grep -q "tests failed" sim.log; then
  echo "Simulation FAILED"
  exit 1
fi

echo "Simulation PASSED"
